//--- logic/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int PC_BITS = 16;
    localparam int XLEN    = 32;

    // pc is halfword aligned so bit 0 is never stored
    typedef logic [PC_BITS-1:1] pc_t;

    // major opcode, instruction bits 6:2
    typedef logic [4:0] opc_t;

    localparam opc_t OPC_LOAD   = 5'b00000;
    localparam opc_t OPC_OP_IMM = 5'b00100;
    localparam opc_t OPC_AUIPC  = 5'b00101;
    localparam opc_t OPC_STORE  = 5'b01000;
    localparam opc_t OPC_OP     = 5'b01100;
    localparam opc_t OPC_LUI    = 5'b01101;
    localparam opc_t OPC_BRANCH = 5'b11000;
    localparam opc_t OPC_JALR   = 5'b11001;
    localparam opc_t OPC_JAL    = 5'b11011;
    localparam opc_t OPC_SYSTEM = 5'b11100;

    // low two bits of every 32-bit encoding
    localparam logic [1:0] OPC_FULL = 2'b11;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opc_t       opc;
        logic [1:0] det;
    } r_fmt_t;

    // funct12 doubles as the csr index for SYSTEM
    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opc_t        opc;
        logic [1:0]  det;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opc_t       opc;
        logic [1:0] det;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opc_t       opc;
        logic [1:0] det;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opc_t        opc;
        logic [1:0]  det;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opc_t       opc;
        logic [1:0] det;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        instr_u instr;
        pc_t    pc;
        pc_t    pc_next;
    } fetch_t;

    typedef struct packed {
        logic add_override;
        logic op2_inverse;
        logic sh_ar;
        logic group_mux;
        logic div_mux;
    } alu_ctrl_t;

    typedef struct packed {
        logic memory;
        logic pc_next;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic op1_src;
        logic op2_src;
        logic reg_write;
        logic inst_jal;
        logic inst_jalr;
        logic inst_branch;
        logic inst_store;
    } dec_ctrl_t;

    typedef struct packed {
        logic [11:0] idx;
        logic [4:0]  imm;
        logic        imm_sel;
        logic        write;
        logic        set;
        logic        clear;
        logic        read;
        logic        ebreak;
        logic        mret;
        logic        csr_req;
    } csr_ctrl_t;

    typedef struct packed {
        logic ecall;
        logic ebreak;
        logic mret;
        logic csr_req;
    } sys_info_t;

endpackage

//--- logic/rv_decode_reg.sv
`timescale 1ns/10ps

module rv_decode_reg
(
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_stall,
    input  logic                    i_flush,
    input  logic                    i_valid,
    input  rv_decode_pkg::fetch_t   i_fetch,
    output rv_decode_pkg::instr_u   o_instr,
    output logic                    o_valid,
    output rv_decode_pkg::pc_t      o_pc,
    output rv_decode_pkg::pc_t      o_pc_next
);

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_instr <= '0;
            o_valid <= 1'b0;
        end
        else if (i_flush)
        begin
            o_instr <= '0;
            o_valid <= 1'b0;
        end
        else if (!i_stall)
        begin
            o_instr <= i_fetch.instr;
            o_valid <= i_valid;
        end
    end

    // pc kept across a flush
    always_ff @(posedge clk)
    begin
        if (!i_flush && !i_stall)
        begin
            o_pc      <= i_fetch.pc;
            o_pc_next <= i_fetch.pc_next;
        end
    end

endmodule

//--- logic/rv_imm_gen.sv
`timescale 1ns/10ps

module rv_imm_gen
(
    input  rv_decode_pkg::instr_u           i_instr,
    output logic [rv_decode_pkg::XLEN-1:0]  o_imm
);

    rv_decode_pkg::opc_t            opc;
    logic [rv_decode_pkg::XLEN-1:0] imm_i;
    logic [rv_decode_pkg::XLEN-1:0] imm_s;
    logic [rv_decode_pkg::XLEN-1:0] imm_b;
    logic [rv_decode_pkg::XLEN-1:0] imm_u;
    logic [rv_decode_pkg::XLEN-1:0] imm_j;

    assign opc = i_instr.r.opc;

    assign imm_i = {{21{i_instr.i.funct12[11]}}, i_instr.i.funct12[10:0]};
    assign imm_s = {{21{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi[5:0], i_instr.s.imm_lo};
    assign imm_b = {{20{i_instr.b.imm_12}}, i_instr.b.imm_11, i_instr.b.imm_10_5,
                    i_instr.b.imm_4_1, 1'b0};
    assign imm_u = {i_instr.u.imm_31_12, 12'b0};
    assign imm_j = {{12{i_instr.j.imm_20}}, i_instr.j.imm_19_12, i_instr.j.imm_11,
                    i_instr.j.imm_10_1, 1'b0};

    // jalr stays on the I form
    assign o_imm = (opc == rv_decode_pkg::OPC_LUI ||
                    opc == rv_decode_pkg::OPC_AUIPC)            ? imm_u :
                   (opc[4:1] == rv_decode_pkg::OPC_JAL[4:1])    ? imm_j :
                   (opc == rv_decode_pkg::OPC_STORE)            ? imm_s :
                   (opc == rv_decode_pkg::OPC_BRANCH)           ? imm_b :
                                                                  imm_i;

endmodule

//--- logic/rv_ctrl_decode.sv
`timescale 1ns/10ps

module rv_ctrl_decode
(
    input  rv_decode_pkg::instr_u       i_instr,
    output logic [4:0]                  o_rs1,
    output rv_decode_pkg::alu_ctrl_t    o_alu_ctrl,
    output rv_decode_pkg::res_src_t     o_res_src,
    output rv_decode_pkg::dec_ctrl_t    o_ctrl
);

    rv_decode_pkg::opc_t opc;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                full;
    logic                is_load, is_op_imm, is_auipc, is_store, is_op;
    logic                is_lui, is_branch, is_jalr, is_jal;
    logic                slt_form, force_inv, add_ovr;

    assign opc    = i_instr.r.opc;
    assign funct3 = i_instr.r.funct3;
    assign funct7 = i_instr.r.funct7;
    assign full   = (i_instr.r.det == rv_decode_pkg::OPC_FULL);

    assign is_load   = (opc == rv_decode_pkg::OPC_LOAD);
    assign is_op_imm = (opc == rv_decode_pkg::OPC_OP_IMM);
    assign is_auipc  = (opc == rv_decode_pkg::OPC_AUIPC);
    assign is_store  = (opc == rv_decode_pkg::OPC_STORE);
    assign is_op     = (opc == rv_decode_pkg::OPC_OP);
    assign is_lui    = (opc == rv_decode_pkg::OPC_LUI);
    assign is_branch = (opc == rv_decode_pkg::OPC_BRANCH);
    assign is_jalr   = (opc == rv_decode_pkg::OPC_JALR);
    assign is_jal    = (opc == rv_decode_pkg::OPC_JAL);

    // lui adds its immediate to x0
    assign o_rs1 = is_lui ? 5'd0 : i_instr.r.rs1;

    // slt/sltu compare by subtraction
    assign slt_form  = (funct3[2:1] == 2'b01);
    assign force_inv = is_branch | (is_op_imm & slt_form) | (is_op & slt_form & !funct7[0]);
    assign add_ovr   = is_load | is_store | is_auipc | is_lui | is_jal;

    assign o_alu_ctrl.add_override = add_ovr;
    assign o_alu_ctrl.op2_inverse  = force_inv             ? 1'b1 :
                                     (add_ovr | is_op_imm) ? 1'b0 :
                                                             funct7[5];
    assign o_alu_ctrl.sh_ar        = funct7[5];
    assign o_alu_ctrl.group_mux    = is_op & funct7[0];
    assign o_alu_ctrl.div_mux      = is_op & funct7[0] & funct3[2];

    assign o_res_src.memory  = full & is_load;
    assign o_res_src.pc_next = is_jal | is_jalr;
    assign o_res_src.alu     = !((full & is_load) | is_jal | is_jalr);

    assign o_ctrl.op1_src     = is_auipc | is_jal;
    assign o_ctrl.op2_src     = !(is_op | is_branch);
    assign o_ctrl.reg_write   = full & !(is_store | is_branch);
    assign o_ctrl.inst_jal    = full & is_jal;
    assign o_ctrl.inst_jalr   = full & is_jalr;
    assign o_ctrl.inst_branch = full & is_branch;
    assign o_ctrl.inst_store  = full & is_store;

endmodule

//--- logic/rv_sys_decode.sv
`timescale 1ns/10ps

module rv_sys_decode
(
    input  rv_decode_pkg::instr_u       i_instr,
    input  logic                        i_flush,
    output rv_decode_pkg::csr_ctrl_t    o_csr,
    output rv_decode_pkg::sys_info_t    o_sys
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic       is_sys, is_trap, csr_req;
    logic       ecall, ebreak, mret;

    assign funct3 = i_instr.r.funct3;
    assign funct7 = i_instr.r.funct7;
    assign rs2    = i_instr.r.rs2;

    assign is_sys = (i_instr.r.det == rv_decode_pkg::OPC_FULL) &&
                    (i_instr.r.opc == rv_decode_pkg::OPC_SYSTEM);

    // trap group is funct3 zero
    assign is_trap = is_sys & (funct3 == 3'b000);
    assign csr_req = is_sys & (funct3 != 3'b000);
    assign ecall   = is_trap & !funct7[3] & !rs2[0];
    assign ebreak  = is_trap & !funct7[3] & rs2[0];
    assign mret    = is_trap & funct7[4] & (rs2[2:1] == 2'b01);

    assign o_csr.idx     = i_instr.i.funct12;
    assign o_csr.imm     = i_instr.r.rs1;
    assign o_csr.imm_sel = funct3[2];
    // no csr side effect from a flushed slot
    assign o_csr.write   = is_sys & (funct3[1:0] == 2'b01) & !i_flush;
    assign o_csr.set     = is_sys & (funct3[1:0] == 2'b10) & !i_flush;
    assign o_csr.clear   = is_sys & (funct3[1:0] == 2'b11) & !i_flush;
    assign o_csr.read    = csr_req;
    assign o_csr.ebreak  = ebreak;
    assign o_csr.mret    = mret;
    assign o_csr.csr_req = csr_req;

    assign o_sys.ecall   = ecall;
    assign o_sys.ebreak  = ebreak;
    assign o_sys.mret    = mret;
    assign o_sys.csr_req = csr_req;

endmodule

//--- logic/rv_legal_check.sv
`timescale 1ns/10ps

module rv_legal_check
(
    input  rv_decode_pkg::instr_u       i_instr,
    input  logic                        i_valid,
    input  rv_decode_pkg::sys_info_t    i_sys,
    output logic                        o_inst_supported
);

    rv_decode_pkg::opc_t opc;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                full;
    logic                plain_ok, op_imm_ok, op_base_ok, op_mul_ok, jalr_ok;

    assign opc    = i_instr.r.opc;
    assign funct3 = i_instr.r.funct3;
    assign funct7 = i_instr.r.funct7;
    assign full   = (i_instr.r.det == rv_decode_pkg::OPC_FULL);

    assign plain_ok = (opc == rv_decode_pkg::OPC_LOAD)  | (opc == rv_decode_pkg::OPC_STORE) |
                      (opc == rv_decode_pkg::OPC_LUI)   | (opc == rv_decode_pkg::OPC_AUIPC) |
                      (opc == rv_decode_pkg::OPC_JAL)   | (opc == rv_decode_pkg::OPC_BRANCH);

    // shifts only allow funct7 bit 5 (srai)
    assign op_imm_ok = (opc == rv_decode_pkg::OPC_OP_IMM) &
                       ((funct3 == 3'b001) ? (funct7 == 7'h00) :
                        (funct3 == 3'b101) ? ((funct7 & 7'h5f) == 7'h00) :
                                             1'b1);

    // sub and sra are the only funct7 0x20 forms
    assign op_base_ok = (opc == rv_decode_pkg::OPC_OP) &
                        ((funct7 == 7'h00) |
                         ((funct7 == 7'h20) & ((funct3 == 3'b000) | (funct3 == 3'b101))));
    assign op_mul_ok  = (opc == rv_decode_pkg::OPC_OP) & (funct7 == 7'h01);
    assign jalr_ok    = (opc == rv_decode_pkg::OPC_JALR) & (funct3 == 3'b000);

    assign o_inst_supported = !i_valid |
                              (full & (plain_ok | op_imm_ok | op_base_ok |
                                       op_mul_ok | jalr_ok)) |
                              i_sys.ecall | i_sys.ebreak | i_sys.mret | i_sys.csr_req;

endmodule

//--- logic/rv_decode_top.sv
`timescale 1ns/10ps

module rv_decode_top
(
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic                        i_ready,
    input  logic [31:0]                 i_instruction,
    input  rv_decode_pkg::pc_t          i_pc,
    input  rv_decode_pkg::pc_t          i_pc_next,
    output rv_decode_pkg::pc_t          o_pc,
    output rv_decode_pkg::pc_t          o_pc_next,
    output logic [4:0]                  o_rs1,
    output logic [4:0]                  o_rs2,
    output logic [4:0]                  o_rd,
    output logic [2:0]                  o_funct3,
    output logic [31:0]                 o_imm,
    output rv_decode_pkg::alu_ctrl_t    o_alu_ctrl,
    output rv_decode_pkg::res_src_t     o_res_src,
    output rv_decode_pkg::dec_ctrl_t    o_ctrl,
    output rv_decode_pkg::csr_ctrl_t    o_csr,
    output logic                        o_inst_supported
);

    rv_decode_pkg::fetch_t    fetch;
    rv_decode_pkg::instr_u    instr;
    rv_decode_pkg::sys_info_t sys_info;
    logic                     valid;

    // bubble when fetch has nothing
    assign fetch.instr   = i_ready ? i_instruction : '0;
    assign fetch.pc      = i_pc;
    assign fetch.pc_next = i_pc_next;

    rv_decode_reg u_reg
    (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_valid    (i_ready),
        .i_fetch    (fetch),
        .o_instr    (instr),
        .o_valid    (valid),
        .o_pc       (o_pc),
        .o_pc_next  (o_pc_next)
    );

    rv_imm_gen u_imm
    (
        .i_instr    (instr),
        .o_imm      (o_imm)
    );

    rv_ctrl_decode u_ctrl
    (
        .i_instr    (instr),
        .o_rs1      (o_rs1),
        .o_alu_ctrl (o_alu_ctrl),
        .o_res_src  (o_res_src),
        .o_ctrl     (o_ctrl)
    );

    rv_sys_decode u_sys
    (
        .i_instr    (instr),
        .i_flush    (i_flush),
        .o_csr      (o_csr),
        .o_sys      (sys_info)
    );

    rv_legal_check u_legal
    (
        .i_instr            (instr),
        .i_valid            (valid),
        .i_sys              (sys_info),
        .o_inst_supported   (o_inst_supported)
    );

    assign o_rs2    = instr.r.rs2;
    assign o_rd     = instr.r.rd;
    assign o_funct3 = instr.r.funct3;

endmodule

//--- tb/tb_rv_decode_enc.svh
`ifndef TB_RV_DECODE_ENC_SVH
`define TB_RV_DECODE_ENC_SVH

// encoders take the 5-bit major opcode and append the low bits 11

function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input rv_decode_pkg::opc_t opc);
    return {f7, rs2, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input rv_decode_pkg::opc_t opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input rv_decode_pkg::opc_t opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc, 2'b11};
endfunction

// bit 0 of a branch offset is not encoded
function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input rv_decode_pkg::opc_t opc);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc, 2'b11};
endfunction

function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                       input rv_decode_pkg::opc_t opc);
    return {imm, rd, opc, 2'b11};
endfunction

function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd,
                                       input rv_decode_pkg::opc_t opc);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc, 2'b11};
endfunction

// sign-extended immediate values as the ISA defines them
function automatic logic [31:0] i_imm_value(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic logic [31:0] b_imm_value(input logic [12:0] v);
    return {{19{v[12]}}, v[12:1], 1'b0};
endfunction

function automatic logic [31:0] u_imm_value(input logic [19:0] v);
    return {v, 12'h000};
endfunction

function automatic logic [31:0] j_imm_value(input logic [20:0] v);
    return {{11{v[20]}}, v[20:1], 1'b0};
endfunction

`endif

//--- tb/tb_rv_decode.sv
`timescale 1ns/10ps

module tb_rv_decode;

    // directed tests take well under this many cycles
    localparam int TEST_CYCLES = 500;
    localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

    logic                       clk;
    logic                       i_rst_n;
    logic                       i_stall;
    logic                       i_flush;
    logic                       i_ready;
    logic [31:0]                i_instruction;
    rv_decode_pkg::pc_t         i_pc;
    rv_decode_pkg::pc_t         i_pc_next;
    rv_decode_pkg::pc_t         o_pc;
    rv_decode_pkg::pc_t         o_pc_next;
    logic [4:0]                 o_rs1;
    logic [4:0]                 o_rs2;
    logic [4:0]                 o_rd;
    logic [2:0]                 o_funct3;
    logic [31:0]                o_imm;
    rv_decode_pkg::alu_ctrl_t   o_alu_ctrl;
    rv_decode_pkg::res_src_t    o_res_src;
    rv_decode_pkg::dec_ctrl_t   o_ctrl;
    rv_decode_pkg::csr_ctrl_t   o_csr;
    logic                       o_inst_supported;
    integer                     seed = 31;
    int                         cycles = 0;
    rv_decode_pkg::pc_t         pc_cnt = '0;

    `include "tb_rv_decode_enc.svh"

    rv_decode_top u_dut
    (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_stall            (i_stall),
        .i_flush            (i_flush),
        .i_ready            (i_ready),
        .i_instruction      (i_instruction),
        .i_pc               (i_pc),
        .i_pc_next          (i_pc_next),
        .o_pc               (o_pc),
        .o_pc_next          (o_pc_next),
        .o_rs1              (o_rs1),
        .o_rs2              (o_rs2),
        .o_rd               (o_rd),
        .o_funct3           (o_funct3),
        .o_imm              (o_imm),
        .o_alu_ctrl         (o_alu_ctrl),
        .o_res_src          (o_res_src),
        .o_ctrl             (o_ctrl),
        .o_csr              (o_csr),
        .o_inst_supported   (o_inst_supported)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            abort_run("timeout: the decode tests did not finish within the cycle limit");
    end

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else
            abort_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // ctrl bits in order op1_src op2_src reg_write jal jalr branch store
    task automatic expect_ctrl(input string name, input logic [6:0] ctrl, input logic [2:0] res);
        expect_eq({name, " o_ctrl"}, 32'(o_ctrl), 32'(ctrl));
        expect_eq({name, " o_res_src"}, 32'(o_res_src), 32'(res));
        expect_eq({name, " o_inst_supported"}, 32'(o_inst_supported), 32'h1);
    endtask

    // drive on the falling edge and check one full cycle later
    task automatic decode_step(input logic [31:0] word);
        pc_cnt        = pc_cnt + 15'd2;
        i_instruction = word;
        i_ready       = 1'b1;
        i_pc          = pc_cnt;
        i_pc_next     = pc_cnt + 15'd2;
        @(posedge clk);
        @(negedge clk);
        expect_eq("o_pc", 32'(o_pc), 32'(pc_cnt));
        expect_eq("o_pc_next", 32'(o_pc_next), 32'(pc_cnt + 15'd2));
    endtask

    task automatic expect_bubble(input string name);
        expect_eq({name, " o_ctrl flags"}, 32'({o_ctrl.reg_write, o_ctrl.inst_store,
                  o_ctrl.inst_branch, o_ctrl.inst_jal, o_ctrl.inst_jalr}), 32'h0);
        expect_eq({name, " o_csr w/s/c/r"}, 32'({o_csr.write, o_csr.set, o_csr.clear,
                  o_csr.read}), 32'h0);
        expect_eq({name, " o_inst_supported"}, 32'(o_inst_supported), 32'h1);
    endtask

    task automatic test_bubbles();
        expect_bubble("reset");
        decode_step(r_word(7'h00, 5'd3, 5'd2, 3'b000, 5'd1, rv_decode_pkg::OPC_OP));
        i_ready       = 1'b0;
        i_instruction = i_word(12'h340, 5'd1, 3'b001, 5'd2, rv_decode_pkg::OPC_SYSTEM);
        @(posedge clk);
        @(negedge clk);
        expect_bubble("ready low");
    endtask

    task automatic arith_case(input string name, input logic is_imm, input logic [6:0] f7,
                              input logic [2:0] f3, input logic inv, input logic grp,
                              input logic div);
        logic [31:0]              rnd;
        logic [31:0]              word;
        rv_decode_pkg::alu_ctrl_t exp_alu;
        rnd = $random(seed);
        if (is_imm)
            word = i_word(rnd[31:20], rnd[4:0], f3, rnd[14:10], rv_decode_pkg::OPC_OP_IMM);
        else
            word = r_word(f7, rnd[9:5], rnd[4:0], f3, rnd[14:10], rv_decode_pkg::OPC_OP);
        exp_alu.add_override = 1'b0;
        exp_alu.op2_inverse  = inv;
        // funct7 bit 5 is instruction bit 30 in both forms
        exp_alu.sh_ar        = is_imm ? rnd[30] : f7[5];
        exp_alu.group_mux    = grp;
        exp_alu.div_mux      = div;
        decode_step(word);
        expect_eq({name, " o_rs1"}, 32'(o_rs1), 32'(rnd[4:0]));
        expect_eq({name, " o_rd"}, 32'(o_rd), 32'(rnd[14:10]));
        expect_eq({name, " o_funct3"}, 32'(o_funct3), 32'(f3));
        if (is_imm)
            expect_eq({name, " o_imm"}, o_imm, i_imm_value(rnd[31:20]));
        else
            expect_eq({name, " o_rs2"}, 32'(o_rs2), 32'(rnd[9:5]));
        expect_ctrl(name, is_imm ? 7'b0110000 : 7'b0010000, 3'b001);
        expect_eq({name, " o_alu_ctrl"}, 32'(o_alu_ctrl), 32'(exp_alu));
    endtask

    task automatic test_arith();
        arith_case("add", 1'b0, 7'h00, 3'b000, 1'b0, 1'b0, 1'b0);
        arith_case("sub", 1'b0, 7'h20, 3'b000, 1'b1, 1'b0, 1'b0);
        arith_case("sra", 1'b0, 7'h20, 3'b101, 1'b1, 1'b0, 1'b0);
        arith_case("slti", 1'b1, 7'h00, 3'b010, 1'b1, 1'b0, 1'b0);
        arith_case("sltiu", 1'b1, 7'h00, 3'b011, 1'b1, 1'b0, 1'b0);
        arith_case("addi", 1'b1, 7'h00, 3'b000, 1'b0, 1'b0, 1'b0);
        arith_case("mul", 1'b0, 7'h01, 3'b000, 1'b0, 1'b1, 1'b0);
        arith_case("div", 1'b0, 7'h01, 3'b100, 1'b0, 1'b1, 1'b1);
    endtask

    task automatic test_imm_src();
        logic [31:0] rnd;
        rnd = $random(seed);
        decode_step(u_word(rnd[31:12], rnd[4:0], rv_decode_pkg::OPC_LUI));
        expect_eq("lui o_imm", o_imm, u_imm_value(rnd[31:12]));
        expect_eq("lui o_rs1", 32'(o_rs1), 32'h0);
        expect_ctrl("lui", 7'b0110000, 3'b001);
        expect_eq("lui add_override", 32'(o_alu_ctrl.add_override), 32'h1);
        rnd = $random(seed);
        decode_step(u_word(rnd[31:12], rnd[4:0], rv_decode_pkg::OPC_AUIPC));
        expect_eq("auipc o_imm", o_imm, u_imm_value(rnd[31:12]));
        expect_ctrl("auipc", 7'b1110000, 3'b001);
        expect_eq("auipc add_override", 32'(o_alu_ctrl.add_override), 32'h1);
        rnd = $random(seed);
        decode_step(j_word(rnd[20:0], rnd[25:21], rv_decode_pkg::OPC_JAL));
        expect_eq("jal o_imm", o_imm, j_imm_value(rnd[20:0]));
        expect_ctrl("jal", 7'b1111000, 3'b010);
        expect_eq("jal add_override", 32'(o_alu_ctrl.add_override), 32'h1);
        rnd = $random(seed);
        decode_step(i_word(rnd[31:20], rnd[4:0], 3'b000, rnd[9:5], rv_decode_pkg::OPC_JALR));
        expect_eq("jalr o_imm", o_imm, i_imm_value(rnd[31:20]));
        expect_ctrl("jalr", 7'b0110100, 3'b010);
        expect_eq("jalr add_override", 32'(o_alu_ctrl.add_override), 32'h0);
        rnd = $random(seed);
        decode_step(b_word(rnd[12:0], rnd[17:13], rnd[22:18], 3'b000,
                           rv_decode_pkg::OPC_BRANCH));
        expect_eq("beq o_imm", o_imm, b_imm_value(rnd[12:0]));
        expect_ctrl("beq", 7'b0000010, 3'b001);
        expect_eq("beq add_override", 32'(o_alu_ctrl.add_override), 32'h0);
        rnd = $random(seed);
        decode_step(s_word(rnd[31:20], rnd[4:0], rnd[9:5], 3'b010, rv_decode_pkg::OPC_STORE));
        expect_eq("sw o_imm", o_imm, i_imm_value(rnd[31:20]));
        expect_ctrl("sw", 7'b0100001, 3'b001);
        expect_eq("sw add_override", 32'(o_alu_ctrl.add_override), 32'h1);
        rnd = $random(seed);
        decode_step(i_word(rnd[31:20], rnd[4:0], 3'b010, rnd[9:5], rv_decode_pkg::OPC_LOAD));
        expect_eq("lw o_imm", o_imm, i_imm_value(rnd[31:20]));
        expect_ctrl("lw", 7'b0110000, 3'b100);
        expect_eq("lw add_override", 32'(o_alu_ctrl.add_override), 32'h1);
    endtask

    task automatic test_stall_flush();
        logic [31:0]        rnd;
        rv_decode_pkg::pc_t held_pc;
        rnd = $random(seed);
        decode_step(i_word(rnd[31:20], rnd[4:0], 3'b000, rnd[9:5], rv_decode_pkg::OPC_OP_IMM));
        held_pc       = pc_cnt;
        i_stall       = 1'b1;
        i_instruction = u_word(rnd[19:0], rnd[24:20], rv_decode_pkg::OPC_LUI);
        i_pc          = held_pc + 15'd8;
        repeat (3)
        begin
            @(posedge clk);
            @(negedge clk);
            expect_eq("stall o_imm", o_imm, i_imm_value(rnd[31:20]));
            expect_eq("stall o_rd", 32'(o_rd), 32'(rnd[9:5]));
            expect_eq("stall o_pc", 32'(o_pc), 32'(held_pc));
        end
        i_stall = 1'b0;
        @(posedge clk);
        @(negedge clk);
        expect_eq("unstall o_imm", o_imm, u_imm_value(rnd[19:0]));
        expect_eq("unstall o_rd", 32'(o_rd), 32'(rnd[24:20]));
        decode_step(i_word(rnd[31:20], rnd[14:10], 3'b001, rnd[9:5], rv_decode_pkg::OPC_SYSTEM));
        expect_eq("csrrw o_csr.write", 32'(o_csr.write), 32'h1);
        held_pc = pc_cnt;
        i_flush = 1'b1;
        i_pc    = held_pc + 15'd8;
        #1;
        expect_eq("flush o_csr.write", 32'(o_csr.write), 32'h0);
        @(posedge clk);
        @(negedge clk);
        i_flush = 1'b0;
        #1;
        expect_bubble("after flush");
        expect_eq("after flush o_pc", 32'(o_pc), 32'(held_pc));
        @(negedge clk);
    endtask

    task automatic sys_case(input string name, input logic [2:0] f3, input logic wr,
                            input logic st, input logic clr, input logic isel);
        logic [31:0]              rnd;
        rv_decode_pkg::csr_ctrl_t exp_csr;
        rnd             = $random(seed);
        exp_csr         = '0;
        exp_csr.idx     = rnd[31:20];
        exp_csr.imm     = rnd[4:0];
        exp_csr.imm_sel = isel;
        exp_csr.write   = wr;
        exp_csr.set     = st;
        exp_csr.clear   = clr;
        exp_csr.read    = 1'b1;
        exp_csr.csr_req = 1'b1;
        decode_step(i_word(rnd[31:20], rnd[4:0], f3, rnd[9:5], rv_decode_pkg::OPC_SYSTEM));
        expect_eq({name, " o_csr"}, 32'(o_csr), 32'(exp_csr));
        expect_eq({name, " o_inst_supported"}, 32'(o_inst_supported), 32'h1);
    endtask

    task automatic trap_case(input string name, input logic [11:0] f12,
                             input logic brk, input logic ret);
        rv_decode_pkg::csr_ctrl_t exp_csr;
        exp_csr        = '0;
        exp_csr.idx    = f12;
        exp_csr.ebreak = brk;
        exp_csr.mret   = ret;
        decode_step(i_word(f12, 5'd0, 3'b000, 5'd0, rv_decode_pkg::OPC_SYSTEM));
        expect_eq({name, " o_csr"}, 32'(o_csr), 32'(exp_csr));
        expect_eq({name, " o_inst_supported"}, 32'(o_inst_supported), 32'h1);
    endtask

    task automatic test_system();
        sys_case("csrrw", 3'b001, 1'b1, 1'b0, 1'b0, 1'b0);
        sys_case("csrrs", 3'b010, 1'b0, 1'b1, 1'b0, 1'b0);
        sys_case("csrrc", 3'b011, 1'b0, 1'b0, 1'b1, 1'b0);
        sys_case("csrrwi", 3'b101, 1'b1, 1'b0, 1'b0, 1'b1);
        trap_case("ecall", 12'h000, 1'b0, 1'b0);
        trap_case("ebreak", 12'h001, 1'b1, 1'b0);
        trap_case("mret", 12'h302, 1'b0, 1'b1);
    endtask

    task automatic reject_case(input string name, input logic [31:0] word);
        decode_step(word);
        expect_eq({name, " o_inst_supported"}, 32'(o_inst_supported), 32'h0);
    endtask

    task automatic test_unsupported();
        logic [31:0] rnd;
        rnd = $random(seed);
        // 5'b10100 is the OP_FP major opcode
        reject_case("fp op", r_word(7'h00, rnd[9:5], rnd[4:0], 3'b000, rnd[14:10], 5'b10100));
        reject_case("low bits 01",
                    r_word(7'h00, rnd[9:5], rnd[4:0], 3'b000, rnd[14:10],
                           rv_decode_pkg::OPC_OP) & ~32'h2);
        reject_case("jalr funct3",
                    i_word(rnd[31:20], rnd[4:0], 3'b001, rnd[9:5], rv_decode_pkg::OPC_JALR));
        reject_case("op funct7 0x10",
                    r_word(7'h10, rnd[9:5], rnd[4:0], 3'b000, rnd[14:10],
                           rv_decode_pkg::OPC_OP));
    endtask

    initial
    begin
        i_rst_n       = 1'b0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_ready       = 1'b0;
        i_instruction = '0;
        i_pc          = '0;
        i_pc_next     = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        test_bubbles();
        test_arith();
        test_imm_src();
        test_stall_flush();
        test_system();
        test_unsupported();
        $display("Test OK");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+tb
logic/rv_decode_pkg.sv
logic/rv_decode_reg.sv
logic/rv_imm_gen.sv
logic/rv_ctrl_decode.sv
logic/rv_sys_decode.sv
logic/rv_legal_check.sv
logic/rv_decode_top.sv
tb/tb_rv_decode.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_decode
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) tb/tb_rv_decode_enc.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
